// ==== files.f ====
+incdir+logic
logic/isa_pkg.sv
logic/rename_pkg.sv
logic/priority_encoder.sv
logic/rename_table.sv
logic/commit_queue.sv
logic/rename_stage.sv
logic/rename_unit.sv
verification/rename_unit_tb.sv

// ==== logic/commit_queue.sv ====
//--------------------------------------------------------------------------
// Commit queue
// In-order ring of previous mappings, one freed per commit pulse
//--------------------------------------------------------------------------

`include "rename_defs.svh"

module commit_queue
  import rename_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  preg_t       push_ppreg,
  input  logic        commit,
  output free_notif_t free
);

  localparam int DEPTH     = `FREE_PREGS;
  localparam int PTR_BITS  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS  = $clog2(DEPTH + 1);

  // Payload, no reset
  preg_t ring [DEPTH];

  logic [PTR_BITS-1:0] head_q;
  logic [PTR_BITS-1:0] tail_q;
  logic [CNT_BITS-1:0] count_q;

  logic do_push;
  logic do_pop;

  // Guards against misuse, environment keeps both in range
  assign do_push = push && (count_q != CNT_BITS'(DEPTH));
  assign do_pop  = commit && (count_q != '0);

  // Head goes straight out on the commit cycle
  assign free.val   = do_pop;
  assign free.ppreg = ring[head_q];

  // Wrap for a depth that need not be a power of two
  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
    if (ptr == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ------------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (do_push) begin
      ring[tail_q] <= push_ppreg;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers and fill level
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        tail_q <= next_ptr(tail_q);
      end
      if (do_pop) begin
        head_q <= next_ptr(head_q);
      end
      // Push and pop together leave the level alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== logic/isa_pkg.sv ====
//--------------------------------------------------------------------------
// ISA-side types
// Architectural register indices and decoded micro-ops
//--------------------------------------------------------------------------

`include "rename_defs.svh"

package isa_pkg;

  // Architectural register index, x0 to x31
  typedef logic [`AREG_BITS-1:0] areg_t;

  // ------------------------------------------------------------------------
  // Decoded micro-op as seen by rename
  // ------------------------------------------------------------------------

  // Only the register fields matter here
  typedef struct packed {
    areg_t rd;
    areg_t rs1;
    areg_t rs2;
  } uop_t;

endpackage

// ==== logic/priority_encoder.sv ====
//--------------------------------------------------------------------------
// Lowest-set-bit selector
// One-hot output marking the lowest set bit of the input
//--------------------------------------------------------------------------

module priority_encoder #(
  parameter int width = 8
) (
  input  logic [width-1:0] in,
  output logic [width-1:0] out
);

  // Bit i set when some bit below i is set
  logic [width-1:0] seen;

  always_comb begin
    seen[0] = 1'b0;
    out[0]  = in[0];
    // Ripple from the bottom, first hit blocks the rest
    for (int i = 1; i < width; i++) begin
      seen[i] = seen[i-1] | in[i-1];
      out[i]  = in[i] & ~seen[i];
    end
  end

endmodule

// ==== logic/rename_defs.svh ====
//--------------------------------------------------------------------------
// Rename sizing macros
// Architectural and physical register counts and index widths
//--------------------------------------------------------------------------

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural register file, x0 included
`define NUM_AREGS 32
`define AREG_BITS 5

// Physical register file
`define NUM_PREGS 36
`define PREG_BITS 6

// Spare physical registers after reset, also commit queue depth
`define FREE_PREGS (`NUM_PREGS - `NUM_AREGS)

`endif

// ==== logic/rename_pkg.sv ====
//--------------------------------------------------------------------------
// Physical-side rename types
// Mappings, completion and free notices, renamed micro-ops
//--------------------------------------------------------------------------

`include "rename_defs.svh"

package rename_pkg;

  import isa_pkg::*;

  // Physical register index
  typedef logic [`PREG_BITS-1:0] preg_t;

  // One map entry per architectural register
  typedef struct packed {
    logic  pending;
    preg_t preg;
  } rt_entry_t;

  // ------------------------------------------------------------------------
  // Notifications into the table
  // ------------------------------------------------------------------------

  // Result written, clear pending
  typedef struct packed {
    logic  val;
    preg_t preg;
  } complete_notif_t;

  // Previous mapping retired, back to the free list
  typedef struct packed {
    logic  val;
    preg_t ppreg;
  } free_notif_t;

  // ------------------------------------------------------------------------
  // Renamed micro-op
  // ------------------------------------------------------------------------

  typedef struct packed {
    areg_t rd;
    preg_t preg;
    preg_t ppreg;
    preg_t rs1_preg;
    logic  rs1_pending;
    preg_t rs2_preg;
    logic  rs2_pending;
  } renamed_uop_t;

endpackage

// ==== logic/rename_stage.sv ====
//--------------------------------------------------------------------------
// Rename stage
// Accepts one micro-op per cycle, drives table and queue, and
// registers the renamed micro-op
//--------------------------------------------------------------------------

`include "rename_defs.svh"

module rename_stage
  import isa_pkg::*, rename_pkg::*;
(
  input  logic         clk,
  input  logic         rst,

  // Upstream
  input  logic         in_val,
  input  uop_t         in_uop,
  output logic         stall,

  // Downstream
  output logic         out_val,
  output renamed_uop_t out_uop,

  // Table lookups
  output areg_t        lookup_areg    [2],
  input  preg_t        lookup_preg    [2],
  input  logic         lookup_pending [2],

  // Table allocation
  output logic         alloc_en,
  output areg_t        alloc_areg,
  input  preg_t        alloc_preg,
  input  preg_t        alloc_ppreg,
  input  logic         free_avail,

  // Commit queue
  output logic         push,
  output preg_t        push_ppreg
);

  logic         accept;
  logic         writes_rd;
  renamed_uop_t next_uop;

  // ------------------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------------------

  assign writes_rd = (in_uop.rd != '0);

  // Only an rd writer can run out of registers
  assign stall  = writes_rd && !free_avail;
  assign accept = in_val && !stall;

  // ------------------------------------------------------------------------
  // Table and queue requests
  // ------------------------------------------------------------------------

  assign lookup_areg[0] = in_uop.rs1;
  assign lookup_areg[1] = in_uop.rs2;

  assign alloc_en   = accept && writes_rd;
  assign alloc_areg = in_uop.rd;

  // Previous mapping queued for the later commit
  assign push       = alloc_en;
  assign push_ppreg = alloc_ppreg;

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------

  // Table already zeroes preg and ppreg for x0
  always_comb begin
    next_uop.rd          = in_uop.rd;
    next_uop.preg        = alloc_preg;
    next_uop.ppreg       = alloc_ppreg;
    next_uop.rs1_preg    = lookup_preg[0];
    next_uop.rs1_pending = lookup_pending[0];
    next_uop.rs2_preg    = lookup_preg[1];
    next_uop.rs2_pending = lookup_pending[1];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else begin
      out_val <= accept;
    end
  end

  // Payload, only valid behind out_val
  always_ff @(posedge clk) begin
    if (accept) begin
      out_uop <= next_uop;
    end
  end

endmodule

// ==== logic/rename_table.sv ====
//--------------------------------------------------------------------------
// Rename table with free list
// Arch-to-phys map with pending bits, lowest-free allocation and
// two source lookup ports with completion bypass
//--------------------------------------------------------------------------

`include "rename_defs.svh"

module rename_table
  import isa_pkg::*, rename_pkg::*;
(
  input  logic            clk,
  input  logic            rst,

  // Source lookups
  input  areg_t           lookup_areg    [2],
  output preg_t           lookup_preg    [2],
  output logic            lookup_pending [2],

  // Destination allocation
  input  logic            alloc_en,
  input  areg_t           alloc_areg,
  output preg_t           alloc_preg,
  output preg_t           alloc_ppreg,
  output logic            free_avail,

  // Notifications
  input  complete_notif_t complete,
  input  free_notif_t     free
);

  // ------------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------------

  // No entry for x0, it is hardwired to preg 0
  rt_entry_t map_q [`NUM_AREGS-1:1];

  // Preg 0 belongs to x0 and never enters the free list
  logic [`NUM_PREGS-1:1] free_q;

  // ------------------------------------------------------------------------
  // Allocation select
  // ------------------------------------------------------------------------

  logic [`NUM_PREGS-1:1] free_sel;
  preg_t                 sel_preg;
  logic                  alloc_fire;

  priority_encoder #(
    .width (`NUM_PREGS-1)
  ) alloc_enc_i (
    .in  (free_q),
    .out (free_sel)
  );

  // One-hot to index
  always_comb begin
    sel_preg = '0;
    for (int i = 1; i < `NUM_PREGS; i++) begin
      if (free_sel[i]) begin
        sel_preg = sel_preg | preg_t'(i);
      end
    end
  end

  assign free_avail = |free_q;

  // x0 destinations never take a register
  assign alloc_fire  = alloc_en && (alloc_areg != '0) && free_avail;
  assign alloc_preg  = (alloc_areg != '0) ? sel_preg : '0;
  assign alloc_ppreg = (alloc_areg != '0) ? map_q[alloc_areg].preg : '0;

  // ------------------------------------------------------------------------
  // Map update
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity mapping, nothing in flight
      for (int i = 1; i < `NUM_AREGS; i++) begin
        map_q[i] <= '{pending: 1'b0, preg: preg_t'(i)};
      end
    end else begin
      for (int i = 1; i < `NUM_AREGS; i++) begin
        // Result written
        if (complete.val && (complete.preg == map_q[i].preg)) begin
          map_q[i].pending <= 1'b0;
        end
        // New mapping wins over a same-cycle clear
        if (alloc_fire && (alloc_areg == areg_t'(i))) begin
          map_q[i] <= '{pending: 1'b1, preg: sel_preg};
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Free list update
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      // Only the spares above the arch count start free
      for (int i = 1; i < `NUM_PREGS; i++) begin
        free_q[i] <= (i >= `NUM_AREGS);
      end
    end else begin
      // Retired previous mapping
      if (free.val && (free.ppreg != '0)) begin
        free_q[free.ppreg] <= 1'b1;
      end
      // Selection came from pre-edge state so never the freed reg
      if (alloc_fire) begin
        free_q[sel_preg] <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Lookups
  // ------------------------------------------------------------------------

  for (genvar k = 0; k < 2; k++) begin : g_lookup
    rt_entry_t entry;
    logic      bypass;

    // x0 reads as preg 0, never pending
    assign entry = (lookup_areg[k] != '0) ? map_q[lookup_areg[k]] : '0;

    // Same-cycle completion seen per port
    assign bypass = complete.val && (complete.preg == entry.preg);

    assign lookup_preg[k]    = entry.preg;
    assign lookup_pending[k] = entry.pending && !bypass;
  end

endmodule

// ==== logic/rename_unit.sv ====
//--------------------------------------------------------------------------
// Register rename unit
// Stage, rename table and commit queue
//--------------------------------------------------------------------------

`include "rename_defs.svh"

module rename_unit
  import isa_pkg::*, rename_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            in_val,
  input  uop_t            in_uop,
  output logic            stall,
  output logic            out_val,
  output renamed_uop_t    out_uop,
  input  complete_notif_t complete,
  input  logic            commit
);

  // Stage to table
  areg_t       lookup_areg    [2];
  preg_t       lookup_preg    [2];
  logic        lookup_pending [2];
  logic        alloc_en;
  areg_t       alloc_areg;
  preg_t       alloc_preg;
  preg_t       alloc_ppreg;
  logic        free_avail;

  // Stage to queue, queue to table
  logic        push;
  preg_t       push_ppreg;
  free_notif_t free;

  rename_stage stage_i (
    .clk            (clk),
    .rst            (rst),
    .in_val         (in_val),
    .in_uop         (in_uop),
    .stall          (stall),
    .out_val        (out_val),
    .out_uop        (out_uop),
    .lookup_areg    (lookup_areg),
    .lookup_preg    (lookup_preg),
    .lookup_pending (lookup_pending),
    .alloc_en       (alloc_en),
    .alloc_areg     (alloc_areg),
    .alloc_preg     (alloc_preg),
    .alloc_ppreg    (alloc_ppreg),
    .free_avail     (free_avail),
    .push           (push),
    .push_ppreg     (push_ppreg)
  );

  rename_table table_i (
    .clk            (clk),
    .rst            (rst),
    .lookup_areg    (lookup_areg),
    .lookup_preg    (lookup_preg),
    .lookup_pending (lookup_pending),
    .alloc_en       (alloc_en),
    .alloc_areg     (alloc_areg),
    .alloc_preg     (alloc_preg),
    .alloc_ppreg    (alloc_ppreg),
    .free_avail     (free_avail),
    .complete       (complete),
    .free           (free)
  );

  commit_queue queue_i (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .push_ppreg (push_ppreg),
    .commit     (commit),
    .free       (free)
  );

endmodule

// ==== verification/rename_unit_tb.sv ====
//--------------------------------------------------------------------------
// Rename unit testbench
// Directed and random renames against a reference model, checked by
// concurrent assertions on stall, out_val and out_uop
//--------------------------------------------------------------------------

`include "rename_defs.svh"

module rename_unit_tb
  import isa_pkg::*, rename_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACCEPT_TIMEOUT = 50;
  localparam int RANDOM_CYCLES  = 600;

  logic            clk;
  logic            rst;
  logic            in_val;
  uop_t            in_uop;
  logic            stall;
  logic            out_val;
  renamed_uop_t    out_uop;
  complete_notif_t complete;
  logic            commit;

  int value_errors = 0;
  int other_errors = 0;

  // ------------------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------------------

  preg_t                 map_m [`NUM_AREGS];
  logic [`NUM_PREGS-1:0] pend_m;
  logic [`NUM_PREGS-1:0] free_m;
  preg_t                 prev_q [$];
  logic                  exp_val;
  renamed_uop_t          exp_uop;
  logic                  exp_stall;

  rename_unit dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_val   (in_val),
    .in_uop   (in_uop),
    .stall    (stall),
    .out_val  (out_val),
    .out_uop  (out_uop),
    .complete (complete),
    .commit   (commit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Only an rd writer waits for a register
  assign exp_stall = (in_uop.rd != '0) && (free_m == '0);

  function automatic preg_t lowest_free(input logic [`NUM_PREGS-1:0] pool);
    for (int i = 1; i < `NUM_PREGS; i++) begin
      if (pool[i]) begin
        return preg_t'(i);
      end
    end
    return '0;
  endfunction

  // Model steps on the same edge, from pre-edge state
  always @(posedge clk) begin : model_update
    renamed_uop_t          pred;
    logic                  take;
    preg_t                 sel;
    logic [`NUM_PREGS-1:0] used;
    preg_t                 held;
    if (rst) begin
      for (int i = 0; i < `NUM_AREGS; i++) begin
        map_m[i] = preg_t'(i);
      end
      pend_m = '0;
      for (int i = 0; i < `NUM_PREGS; i++) begin
        free_m[i] = (i >= `NUM_AREGS);
      end
      prev_q.delete();
      exp_val <= 1'b0;
    end else begin
      // No physical register held by two arch registers in the DUT map
      used = '0;
      for (int a = 1; a < `NUM_AREGS; a++) begin
        held = dut_i.table_i.map_q[a].preg;
        assert (!used[held]) else begin
          other_errors++;
          $display("Physical register %0d is mapped by more than one register", held);
        end
        used[held] = 1'b1;
      end
      take = in_val && !exp_stall;
      sel  = lowest_free(free_m);
      pred.rd          = in_uop.rd;
      pred.preg        = (in_uop.rd != '0) ? sel : '0;
      pred.ppreg       = map_m[in_uop.rd];
      pred.rs1_preg    = map_m[in_uop.rs1];
      pred.rs2_preg    = map_m[in_uop.rs2];
      // Completion in the same cycle hides the pending bit
      pred.rs1_pending = pend_m[pred.rs1_preg]
                         && !(complete.val && complete.preg == pred.rs1_preg);
      pred.rs2_pending = pend_m[pred.rs2_preg]
                         && !(complete.val && complete.preg == pred.rs2_preg);
      if (complete.val) begin
        pend_m[complete.preg] = 1'b0;
      end
      // Oldest previous mapping goes back to the pool
      if (commit && prev_q.size() > 0) begin
        free_m[prev_q.pop_front()] = 1'b1;
      end
      if (take && in_uop.rd != '0) begin
        prev_q.push_back(map_m[in_uop.rd]);
        map_m[in_uop.rd] = sel;
        pend_m[sel]      = 1'b1;
        free_m[sel]      = 1'b0;
      end
      exp_val <= take;
      if (take) begin
        exp_uop <= pred;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Output checks
  // ------------------------------------------------------------------------

  assert property (@(posedge clk) disable iff (rst) stall == exp_stall)
    else begin
      value_errors++;
      $display("CHECK FAILED stall: got %h, expected %h", $sampled(stall), $sampled(exp_stall));
    end

  assert property (@(posedge clk) disable iff (rst) out_val == exp_val)
    else begin
      value_errors++;
      $display("CHECK FAILED out_val: got %h, expected %h",
               $sampled(out_val), $sampled(exp_val));
    end

  assert property (@(posedge clk) disable iff (rst) out_val |-> out_uop == exp_uop)
    else begin
      value_errors++;
      $display("CHECK FAILED out_uop: got %h, expected %h",
               $sampled(out_uop), $sampled(exp_uop));
    end

  // ------------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------------

  // One cycle of inputs, taken sampled once stall has settled
  task automatic step(input logic val, input uop_t uop, input logic cmt,
                      input complete_notif_t cpl, output logic taken);
    @(negedge clk);
    in_val   = val;
    in_uop   = uop;
    commit   = cmt;
    complete = cpl;
    #2;
    taken = val && !stall;
  endtask

  function automatic uop_t make_uop(input areg_t rd, input areg_t rs1, input areg_t rs2);
    return '{rd: rd, rs1: rs1, rs2: rs2};
  endfunction

  function automatic complete_notif_t done_notice(input preg_t p);
    return '{val: 1'b1, preg: p};
  endfunction

  // Hold the micro-op until it goes through
  task automatic rename_uop(input areg_t rd, input areg_t rs1, input areg_t rs2);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken) begin
      if (waited == ACCEPT_TIMEOUT) begin
        other_errors++;
        $display("Timeout: micro-op rd=%0d never accepted", rd);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display("TESTBENCH FAILED");
        $finish;
      end else begin
        step(1'b1, make_uop(rd, rs1, rs2), 1'b0, '0, taken);
        waited++;
      end
    end
  endtask

  task automatic idle(input int cycles);
    logic taken;
    for (int i = 0; i < cycles; i++) begin
      step(1'b0, '0, 1'b0, '0, taken);
    end
  endtask

  initial begin : stimulus
    logic taken;
    logic hold;
    logic val;
    logic cmt;
    uop_t uop;
    rst      = 1'b1;
    in_val   = 1'b0;
    in_uop   = '0;
    complete = '0;
    commit   = 1'b0;
    void'($urandom(32'hc559310e));
    repeat (4) @(negedge clk);
    rst = 1'b0;

    // Spares handed out in order, sources see old or new mappings
    rename_uop(5'd1, 5'd2, 5'd3);
    rename_uop(5'd2, 5'd1, 5'd2);
    rename_uop(5'd3, 5'd3, 5'd0);
    rename_uop(5'd1, 5'd1, 5'd2);

    // x0 destination with an empty pool
    rename_uop(5'd0, 5'd1, 5'd2);

    // Pool empty, hold until a commit frees the oldest ppreg
    step(1'b1, make_uop(5'd4, 5'd1, 5'd3), 1'b0, '0, taken);
    assert (!taken) else begin
      other_errors++;
      $display("Micro-op accepted with no free physical register");
    end
    step(1'b1, make_uop(5'd4, 5'd1, 5'd3), 1'b1, '0, taken);
    rename_uop(5'd4, 5'd1, 5'd3);

    // Same-cycle completion bypass on one port only
    step(1'b1, make_uop(5'd0, 5'd2, 5'd3), 1'b0, done_notice(6'd33), taken);
    rename_uop(5'd0, 5'd2, 5'd3);
    step(1'b0, '0, 1'b0, done_notice(6'd34), taken);
    rename_uop(5'd0, 5'd3, 5'd4);
    idle(2);

    // Random mix, stalled micro-ops held in place
    hold = 1'b0;
    val  = 1'b0;
    cmt  = 1'b0;
    uop  = '0;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      if (!hold) begin
        val     = ($urandom_range(3) != 0);
        uop.rd  = ($urandom_range(7) == 0) ? '0 : areg_t'($urandom_range(31));
        uop.rs1 = areg_t'($urandom_range(31));
        uop.rs2 = areg_t'($urandom_range(31));
      end
      // Never commit more than was renamed, the commit still in flight included
      cmt = (prev_q.size() > int'(cmt)) && ($urandom_range(3) == 0);
      step(val, uop, cmt,
           '{val: logic'($urandom_range(1)), preg: preg_t'($urandom_range(`NUM_PREGS-1))},
           taken);
      hold = val && !taken;
    end
    idle(3);

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
